// ==== design/mcu_ctrl_pkg.sv ====
////////////////////////////////////////////////////////////
// request encoding and default sizes for the always-on
// power and fast interrupt controller
////////////////////////////////////////////////////////////

package mcu_ctrl_pkg;

  // default count of retentive memory banks
  localparam int NUM_BANKS_DEF = 2;

  // default width of the fast interrupt vector
  localparam int NUM_FAST_DEF = 16;

  // what the power manager asks of one domain sequencer
  typedef enum logic [1:0] {
    // domain stays powered and clocked
    PWR_REQ_ON     = 2'b00,
    // full power gating through the switch
    PWR_REQ_OFF    = 2'b01,
    // clock gated, memory contents held
    PWR_REQ_RETAIN = 2'b10
  } pwr_req_e;

endpackage

// ==== design/pwr_ctrl_if.sv ====
////////////////////////////////////////////////////////////
// power control bundle of one domain, every signal active low
////////////////////////////////////////////////////////////

interface pwr_ctrl_if;

  logic switch_n;
  logic switch_ack_n;
  logic iso_n;
  logic rst_n;
  logic clkgate_en_n;
  logic retentive_n;

  // sequencer side
  modport seq (
    output switch_n,
    output iso_n,
    output rst_n,
    output clkgate_en_n,
    output retentive_n,
    input  switch_ack_n
  );

  // switch cell and pad side
  modport pad (
    input  switch_n,
    input  iso_n,
    input  rst_n,
    input  clkgate_en_n,
    input  retentive_n,
    output switch_ack_n
  );

endinterface

// ==== design/pwr_domain_seq.sv ====
////////////////////////////////////////////////////////////
// switch_ack_n must already be synchronous to clk_i
// a started sequence always runs to completion
////////////////////////////////////////////////////////////

module pwr_domain_seq #(
  parameter bit HAS_RETENTION = 1'b0
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mcu_ctrl_pkg::pwr_req_e req_i,
  pwr_ctrl_if.seq                pwr
);

  import mcu_ctrl_pkg::*;

  typedef enum logic [3:0] {
    ST_ON,
    ST_CG_OFF,
    ST_ISO_OFF,
    ST_RST_OFF,
    ST_SW_OFF,
    ST_OFF,
    ST_SW_ON,
    ST_RST_ON,
    ST_ISO_ON,
    ST_RET_IN,
    ST_RET,
    ST_RET_OUT
  } state_e;

  state_e state_q;
  logic   switch_q;
  logic   iso_q;
  logic   rst_q;
  logic   clkgate_q;
  logic   retentive_q;
  logic   ret_req;

  // without retention a retain request reads as on
  assign ret_req = HAS_RETENTION && (req_i == PWR_REQ_RETAIN);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= ST_ON;
      switch_q    <= 1'b1;
      iso_q       <= 1'b1;
      rst_q       <= 1'b1;
      clkgate_q   <= 1'b1;
      retentive_q <= 1'b1;
    end else begin
      case (state_q)
        ST_ON: begin
          if (req_i == PWR_REQ_OFF) begin
            clkgate_q <= 1'b0;
            state_q   <= ST_CG_OFF;
          end else if (ret_req) begin
            clkgate_q <= 1'b0;
            state_q   <= ST_RET_IN;
          end
        end
        // power-down, one control per cycle
        ST_CG_OFF: begin
          iso_q   <= 1'b0;
          state_q <= ST_ISO_OFF;
        end
        ST_ISO_OFF: begin
          rst_q   <= 1'b0;
          state_q <= ST_RST_OFF;
        end
        ST_RST_OFF: begin
          switch_q <= 1'b0;
          state_q  <= ST_SW_OFF;
        end
        // hold until the switch reports off
        ST_SW_OFF: begin
          if (!pwr.switch_ack_n) begin
            state_q <= ST_OFF;
          end
        end
        ST_OFF: begin
          if (req_i != PWR_REQ_OFF) begin
            switch_q <= 1'b1;
            state_q  <= ST_SW_ON;
          end
        end
        // supply back, then reset, isolation, clock
        ST_SW_ON: begin
          if (pwr.switch_ack_n) begin
            rst_q   <= 1'b1;
            state_q <= ST_RST_ON;
          end
        end
        ST_RST_ON: begin
          iso_q   <= 1'b1;
          state_q <= ST_ISO_ON;
        end
        ST_ISO_ON: begin
          clkgate_q <= 1'b1;
          state_q   <= ST_ON;
        end
        ST_RET_IN: begin
          retentive_q <= 1'b0;
          state_q     <= ST_RET;
        end
        // an off request from here goes back through on
        ST_RET: begin
          if (req_i != PWR_REQ_RETAIN) begin
            retentive_q <= 1'b1;
            state_q     <= ST_RET_OUT;
          end
        end
        ST_RET_OUT: begin
          clkgate_q <= 1'b1;
          state_q   <= ST_ON;
        end
        default: begin
          state_q <= ST_ON;
        end
      endcase
    end
  end

  assign pwr.switch_n     = switch_q;
  assign pwr.iso_n        = iso_q;
  assign pwr.rst_n        = rst_q;
  assign pwr.clkgate_en_n = clkgate_q;
  assign pwr.retentive_n  = retentive_q;

endmodule

// ==== design/power_manager.sv ====
////////////////////////////////////////////////////////////
// requests are combinational from the level inputs
// a pending fast interrupt always overrides cpu sleep
////////////////////////////////////////////////////////////

module power_manager #(
  parameter int NUM_BANKS = mcu_ctrl_pkg::NUM_BANKS_DEF,
  parameter int NUM_FAST  = mcu_ctrl_pkg::NUM_FAST_DEF
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 core_sleep_i,
  input  logic                 cpu_pwr_down_en_i,
  input  logic                 periph_off_i,
  input  logic [NUM_BANKS-1:0] bank_off_i,
  input  logic [NUM_BANKS-1:0] bank_retain_i,
  input  logic [NUM_FAST-1:0]  fast_pending_i,
  pwr_ctrl_if.seq              cpu_pwr,
  pwr_ctrl_if.seq              periph_pwr,
  pwr_ctrl_if.seq              bank_pwr [NUM_BANKS-1:0]
);

  import mcu_ctrl_pkg::*;

  pwr_req_e cpu_req;
  pwr_req_e periph_req;
  pwr_req_e bank_req [NUM_BANKS];
  logic     cpu_can_sleep;

  // wake-up on any pending fast line
  assign cpu_can_sleep = core_sleep_i & cpu_pwr_down_en_i & ~(|fast_pending_i);

  assign cpu_req    = cpu_can_sleep ? PWR_REQ_OFF : PWR_REQ_ON;
  assign periph_req = periph_off_i ? PWR_REQ_OFF : PWR_REQ_ON;

  // off beats retain
  always_comb begin
    for (int k = 0; k < NUM_BANKS; k++) begin
      if (bank_off_i[k]) begin
        bank_req[k] = PWR_REQ_OFF;
      end else if (bank_retain_i[k]) begin
        bank_req[k] = PWR_REQ_RETAIN;
      end else begin
        bank_req[k] = PWR_REQ_ON;
      end
    end
  end

  pwr_domain_seq #(
    .HAS_RETENTION(1'b0)
  ) cpu_seq_i (
    .clk_i,
    .rst_n_i,
    .req_i(cpu_req),
    .pwr  (cpu_pwr)
  );

  pwr_domain_seq #(
    .HAS_RETENTION(1'b0)
  ) periph_seq_i (
    .clk_i,
    .rst_n_i,
    .req_i(periph_req),
    .pwr  (periph_pwr)
  );

  for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
    pwr_domain_seq #(
      .HAS_RETENTION(1'b1)
    ) bank_seq_i (
      .clk_i,
      .rst_n_i,
      .req_i(bank_req[k]),
      .pwr  (bank_pwr[k])
    );
  end

endmodule

// ==== design/fast_intr_ctrl.sv ====
////////////////////////////////////////////////////////////
// sources sampled on clk_i, rising edge sets pending
// set wins over a clear on the same edge
////////////////////////////////////////////////////////////

module fast_intr_ctrl #(
  parameter int NUM_FAST = mcu_ctrl_pkg::NUM_FAST_DEF
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [NUM_FAST-1:0] fast_intr_i,
  input  logic                fast_clr_i,
  input  logic [NUM_FAST-1:0] fast_clr_mask_i,
  output logic [NUM_FAST-1:0] pending_o
);

  logic [NUM_FAST-1:0] intr_q;
  logic [NUM_FAST-1:0] pending_q;
  logic [NUM_FAST-1:0] rise;
  logic [NUM_FAST-1:0] clr;

  // low last cycle, high now
  assign rise = fast_intr_i & ~intr_q;

  // mask only counts during the clear pulse
  assign clr = fast_clr_i ? fast_clr_mask_i : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      intr_q <= '0;
    end else begin
      intr_q <= fast_intr_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~clr) | rise;
    end
  end

  assign pending_o = pending_q;

endmodule

// ==== design/mcu_ao_ctrl_top.sv ====
////////////////////////////////////////////////////////////
// acks must be synchronous to clk_i; debug reset gates only
// the cpu and peripheral resets, banks have no reset output
////////////////////////////////////////////////////////////

module mcu_ao_ctrl_top #(
  parameter int NUM_BANKS = mcu_ctrl_pkg::NUM_BANKS_DEF,
  parameter int NUM_FAST  = mcu_ctrl_pkg::NUM_FAST_DEF
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 debug_reset_n_i,

  input  logic                 core_sleep_i,
  input  logic                 cpu_pwr_down_en_i,
  input  logic                 cpu_switch_ack_n_i,
  output logic                 cpu_switch_n_o,
  output logic                 cpu_iso_n_o,
  output logic                 cpu_rst_n_o,

  input  logic                 periph_off_i,
  input  logic                 periph_switch_ack_n_i,
  output logic                 periph_switch_n_o,
  output logic                 periph_iso_n_o,
  output logic                 periph_rst_n_o,
  output logic                 periph_clkgate_en_n_o,

  input  logic [NUM_BANKS-1:0] bank_off_i,
  input  logic [NUM_BANKS-1:0] bank_retain_i,
  input  logic [NUM_BANKS-1:0] bank_switch_ack_n_i,
  output logic [NUM_BANKS-1:0] bank_switch_n_o,
  output logic [NUM_BANKS-1:0] bank_iso_n_o,
  output logic [NUM_BANKS-1:0] bank_retentive_n_o,
  output logic [NUM_BANKS-1:0] bank_clkgate_en_n_o,

  input  logic [NUM_FAST-1:0]  fast_intr_i,
  input  logic                 fast_clr_i,
  input  logic [NUM_FAST-1:0]  fast_clr_mask_i,
  output logic [NUM_FAST-1:0]  irq_fast_o
);

  logic [NUM_FAST-1:0] fast_pending;

  pwr_ctrl_if cpu_pwr ();
  pwr_ctrl_if periph_pwr ();
  pwr_ctrl_if bank_pwr [NUM_BANKS-1:0] ();

  fast_intr_ctrl #(
    .NUM_FAST(NUM_FAST)
  ) fast_intr_ctrl_i (
    .clk_i,
    .rst_n_i,
    .fast_intr_i,
    .fast_clr_i,
    .fast_clr_mask_i,
    .pending_o(fast_pending)
  );

  power_manager #(
    .NUM_BANKS(NUM_BANKS),
    .NUM_FAST (NUM_FAST)
  ) power_manager_i (
    .clk_i,
    .rst_n_i,
    .core_sleep_i,
    .cpu_pwr_down_en_i,
    .periph_off_i,
    .bank_off_i,
    .bank_retain_i,
    .fast_pending_i(fast_pending),
    .cpu_pwr       (cpu_pwr),
    .periph_pwr    (periph_pwr),
    .bank_pwr      (bank_pwr)
  );

  assign irq_fast_o = fast_pending;

  // cpu domain
  assign cpu_pwr.switch_ack_n = cpu_switch_ack_n_i;
  assign cpu_switch_n_o       = cpu_pwr.switch_n;
  assign cpu_iso_n_o          = cpu_pwr.iso_n;
  // debug ndmreset holds the core in reset
  assign cpu_rst_n_o          = cpu_pwr.rst_n & debug_reset_n_i;

  // peripheral domain
  assign periph_pwr.switch_ack_n = periph_switch_ack_n_i;
  assign periph_switch_n_o       = periph_pwr.switch_n;
  assign periph_iso_n_o          = periph_pwr.iso_n;
  assign periph_rst_n_o          = periph_pwr.rst_n & debug_reset_n_i;
  assign periph_clkgate_en_n_o   = periph_pwr.clkgate_en_n;

  for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank_pads
    assign bank_pwr[k].switch_ack_n = bank_switch_ack_n_i[k];
    assign bank_switch_n_o[k]       = bank_pwr[k].switch_n;
    assign bank_iso_n_o[k]          = bank_pwr[k].iso_n;
    assign bank_retentive_n_o[k]    = bank_pwr[k].retentive_n;
    assign bank_clkgate_en_n_o[k]   = bank_pwr[k].clkgate_en_n;
  end

endmodule

// ==== testbench/tb_mcu_ao_ctrl.sv ====
////////////////////////////////////////////////////////////
// runs two banks and sixteen fast lines; switch acks are
// driven directly by the tests, there is no switch cell model
////////////////////////////////////////////////////////////

module tb_mcu_ao_ctrl;

  localparam int NUM_BANKS     = 2;
  localparam int NUM_FAST      = 16;
  localparam int CLK_PERIOD    = 10;
  localparam int TEST_CYCLES   = 130;
  localparam int MARGIN_CYCLES = 200;
  localparam logic [31:0] SEED = 32'h9ca6_80a1;

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 debug_reset_n_i;
  logic                 core_sleep_i;
  logic                 cpu_pwr_down_en_i;
  logic                 cpu_switch_ack_n_i;
  logic                 cpu_switch_n_o;
  logic                 cpu_iso_n_o;
  logic                 cpu_rst_n_o;
  logic                 periph_off_i;
  logic                 periph_switch_ack_n_i;
  logic                 periph_switch_n_o;
  logic                 periph_iso_n_o;
  logic                 periph_rst_n_o;
  logic                 periph_clkgate_en_n_o;
  logic [NUM_BANKS-1:0] bank_off_i;
  logic [NUM_BANKS-1:0] bank_retain_i;
  logic [NUM_BANKS-1:0] bank_switch_ack_n_i;
  logic [NUM_BANKS-1:0] bank_switch_n_o;
  logic [NUM_BANKS-1:0] bank_iso_n_o;
  logic [NUM_BANKS-1:0] bank_retentive_n_o;
  logic [NUM_BANKS-1:0] bank_clkgate_en_n_o;
  logic [NUM_FAST-1:0]  fast_intr_i;
  logic                 fast_clr_i;
  logic [NUM_FAST-1:0]  fast_clr_mask_i;
  logic [NUM_FAST-1:0]  irq_fast_o;

  int          errors;
  logic [31:0] lfsr_state;

  mcu_ao_ctrl_top #(
    .NUM_BANKS(NUM_BANKS),
    .NUM_FAST (NUM_FAST)
  ) uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("watchdog expired, tests still running after %0d cycles",
             TEST_CYCLES + MARGIN_CYCLES);
    $display("Test failed");
    $finish;
  end

  // taps 32 22 2 1
  function automatic logic [15:0] random_bits(input int n);
    logic [15:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[14:0], fb};
    end
    return r;
  endfunction

  // one control per hex digit so error lines read directly
  function automatic logic [15:0] cpu_vec();
    return {7'h0, cpu_iso_n_o, 3'h0, cpu_rst_n_o, 3'h0, cpu_switch_n_o};
  endfunction

  function automatic logic [15:0] periph_vec();
    return {3'h0, periph_clkgate_en_n_o, 3'h0, periph_iso_n_o,
            3'h0, periph_rst_n_o, 3'h0, periph_switch_n_o};
  endfunction

  function automatic logic [15:0] bank_vec(input int k);
    return {3'h0, bank_clkgate_en_n_o[k], 3'h0, bank_iso_n_o[k],
            3'h0, bank_retentive_n_o[k], 3'h0, bank_switch_n_o[k]};
  endfunction

  task expect_eq(input string what, input logic [15:0] got, input logic [15:0] want);
    if (got !== want) begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task check_banks(input logic [15:0] want0, input logic [15:0] want1);
    @(negedge clk_i);
    expect_eq("bank0 controls", bank_vec(0), want0);
    expect_eq("bank1 controls", bank_vec(1), want1);
  endtask

  task clear_pulse(input logic [15:0] mask);
    @(posedge clk_i);
    fast_clr_i      <= 1'b1;
    fast_clr_mask_i <= mask;
    @(posedge clk_i);
    fast_clr_i      <= 1'b0;
    fast_clr_mask_i <= '0;
    @(negedge clk_i);
  endtask

  task wait_cpu_switch(input logic level, input int limit);
    int n;
    n = 0;
    while (cpu_switch_n_o !== level && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    if (cpu_switch_n_o !== level) begin
      errors++;
      $display("%0t: cpu power switch did not turn %s within %0d cycles",
               $time, level ? "on" : "off", limit);
    end
  endtask

  task reset_state_test;
    @(negedge clk_i);
    expect_eq("cpu controls", cpu_vec(), 16'h0111);
    expect_eq("periph controls", periph_vec(), 16'h1111);
    expect_eq("bank0 controls", bank_vec(0), 16'h1111);
    expect_eq("bank1 controls", bank_vec(1), 16'h1111);
    expect_eq("irq_fast_o", irq_fast_o, 16'h0000);
  endtask

  task fast_intr_test;
    logic [15:0] lines;
    logic [15:0] mask;
    lines = random_bits(16) | 16'h0001;
    @(posedge clk_i);
    fast_intr_i <= lines;
    @(negedge clk_i);
    expect_eq("irq before edge", irq_fast_o, 16'h0000);
    @(negedge clk_i);
    expect_eq("irq after rise", irq_fast_o, lines);
    // sources stay high through the clear
    clear_pulse(16'hffff);
    expect_eq("irq after full clear", irq_fast_o, 16'h0000);
    repeat (2) @(negedge clk_i);
    expect_eq("irq with held sources", irq_fast_o, 16'h0000);
    @(posedge clk_i);
    fast_intr_i <= '0;
    lines = random_bits(16) | 16'h0001;
    @(posedge clk_i);
    fast_intr_i <= lines;
    repeat (2) @(negedge clk_i);
    mask = random_bits(16);
    clear_pulse(mask);
    expect_eq("irq after masked clear", irq_fast_o, lines & ~mask);
    // new edge on the same clock as a full clear
    @(posedge clk_i);
    fast_intr_i <= '0;
    lines = random_bits(16) | 16'h0001;
    @(posedge clk_i);
    fast_intr_i     <= lines;
    fast_clr_i      <= 1'b1;
    fast_clr_mask_i <= 16'hffff;
    @(posedge clk_i);
    fast_clr_i      <= 1'b0;
    fast_clr_mask_i <= '0;
    @(negedge clk_i);
    expect_eq("irq set against clear", irq_fast_o, lines);
    @(posedge clk_i);
    fast_intr_i <= '0;
    clear_pulse(16'hffff);
    expect_eq("irq after cleanup", irq_fast_o, 16'h0000);
  endtask

  task periph_power_test;
    logic [15:0] want;
    int          hold;
    want = 16'h1111;
    @(posedge clk_i);
    periph_off_i <= 1'b1;
    for (int i = 0; i < 5; i++) begin
      @(negedge clk_i);
      expect_eq("periph power-down", periph_vec(), want);
      want = want >> 4;
    end
    hold = 1 + int'(random_bits(3));
    repeat (hold) begin
      @(negedge clk_i);
      expect_eq("periph waiting on ack", periph_vec(), 16'h0000);
    end
    @(posedge clk_i);
    periph_switch_ack_n_i <= 1'b0;
    periph_off_i          <= 1'b0;
    for (int i = 0; i < 5; i++) begin
      @(negedge clk_i);
      expect_eq("periph switch on", periph_vec(), (i < 2) ? 16'h0000 : 16'h0001);
    end
    @(posedge clk_i);
    periph_switch_ack_n_i <= 1'b1;
    want = 16'h0001;
    for (int i = 0; i < 4; i++) begin
      @(negedge clk_i);
      expect_eq("periph power-up", periph_vec(), want);
      want = {want[11:0], 4'h1};
    end
  endtask

  task bank_power_test;
    @(posedge clk_i);
    bank_retain_i[0] <= 1'b1;
    check_banks(16'h1111, 16'h1111);
    check_banks(16'h0111, 16'h1111);
    repeat (2) check_banks(16'h0101, 16'h1111);
    @(posedge clk_i);
    bank_retain_i[0] <= 1'b0;
    check_banks(16'h0101, 16'h1111);
    check_banks(16'h0111, 16'h1111);
    check_banks(16'h1111, 16'h1111);
    // bank 1 off while bank 0 stays on
    @(posedge clk_i);
    bank_off_i[1] <= 1'b1;
    check_banks(16'h1111, 16'h1111);
    check_banks(16'h1111, 16'h0111);
    repeat (2) check_banks(16'h1111, 16'h0011);
    check_banks(16'h1111, 16'h0010);
    @(posedge clk_i);
    bank_switch_ack_n_i[1] <= 1'b0;
    bank_off_i[1]          <= 1'b0;
    repeat (2) check_banks(16'h1111, 16'h0010);
    check_banks(16'h1111, 16'h0011);
    @(posedge clk_i);
    bank_switch_ack_n_i[1] <= 1'b1;
    repeat (2) check_banks(16'h1111, 16'h0011);
    check_banks(16'h1111, 16'h0111);
    check_banks(16'h1111, 16'h1111);
  endtask

  task cpu_sleep_test;
    int line;
    line = int'(random_bits(4));
    @(posedge clk_i);
    core_sleep_i      <= 1'b1;
    cpu_pwr_down_en_i <= 1'b1;
    wait_cpu_switch(1'b0, 8);
    expect_eq("cpu powered down", cpu_vec(), 16'h0000);
    @(posedge clk_i);
    cpu_switch_ack_n_i <= 1'b0;
    repeat (2) @(negedge clk_i);
    expect_eq("cpu held off", cpu_vec(), 16'h0000);
    // pending line overrides sleep
    @(posedge clk_i);
    fast_intr_i[line] <= 1'b1;
    wait_cpu_switch(1'b1, 6);
    expect_eq("wake-up pending", irq_fast_o, 16'h0001 << line);
    expect_eq("cpu waiting on ack", cpu_vec(), 16'h0001);
    @(posedge clk_i);
    cpu_switch_ack_n_i <= 1'b1;
    repeat (2) @(negedge clk_i);
    expect_eq("cpu reset released", cpu_vec(), 16'h0011);
    @(negedge clk_i);
    expect_eq("cpu isolation released", cpu_vec(), 16'h0111);
    @(posedge clk_i);
    core_sleep_i <= 1'b0;
    fast_intr_i  <= '0;
    clear_pulse(16'hffff);
    @(posedge clk_i);
    debug_reset_n_i <= 1'b0;
    @(negedge clk_i);
    expect_eq("resets under debug", {14'h0, cpu_rst_n_o, periph_rst_n_o}, 16'h0000);
    @(posedge clk_i);
    debug_reset_n_i <= 1'b1;
    @(negedge clk_i);
    expect_eq("resets after debug", {14'h0, cpu_rst_n_o, periph_rst_n_o}, 16'h0003);
  endtask

  initial begin
    errors                = 0;
    lfsr_state            = SEED;
    rst_n_i               <= 1'b0;
    debug_reset_n_i       <= 1'b1;
    core_sleep_i          <= 1'b0;
    cpu_pwr_down_en_i     <= 1'b0;
    cpu_switch_ack_n_i    <= 1'b1;
    periph_off_i          <= 1'b0;
    periph_switch_ack_n_i <= 1'b1;
    bank_off_i            <= '0;
    bank_retain_i         <= '0;
    bank_switch_ack_n_i   <= '1;
    fast_intr_i           <= '0;
    fast_clr_i            <= 1'b0;
    fast_clr_mask_i       <= '0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    reset_state_test;
    fast_intr_test;
    periph_power_test;
    bank_power_test;
    cpu_sleep_test;
    repeat (2) @(posedge clk_i);
    $display("all tests done with %0d errors", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
design/mcu_ctrl_pkg.sv
design/pwr_ctrl_if.sv
design/pwr_domain_seq.sv
design/power_manager.sv
design/fast_intr_ctrl.sv
design/mcu_ao_ctrl_top.sv
testbench/tb_mcu_ao_ctrl.sv

// ==== Makefile ====
# Verilator simulation of the always-on power and fast interrupt controller

VERILATOR ?= verilator
TOP       ?= tb_mcu_ao_ctrl
LOG       ?= sim.log
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
